//--- src/sdram_test_config.svh
// all timings are in clk cycles at one clk per SDRAM clock; the address map assumes 4 banks
`ifndef SDRAM_TEST_CONFIG_SVH
`define SDRAM_TEST_CONFIG_SVH

// uart bit time, short so simulation stays quick
`define SDT_CLKS_PER_BIT 8

// logical byte address is bank:row:column
`define SDT_ADDR_W 24
`define SDT_ROW_W 13
`define SDT_COL_W 9

// SDRAM timing
`define SDT_T_INIT 200
`define SDT_T_REFI 750
`define SDT_T_RC 6
`define SDT_T_RCD 2
`define SDT_T_RP 2
`define SDT_CAS 2

// background writer and transmit buffer
`define SDT_WRITE_INTERVAL 64
`define SDT_TX_FIFO_DEPTH 16

`endif

//--- src/sdram_test_pkg.sv
// types only; the address width follows the config header and nop is sent as a deselect
`default_nettype none

`include "sdram_test_config.svh"

package sdram_test_pkg;

	// byte address, bank in the top bits, column in the bottom bits
	typedef logic [`SDT_ADDR_W-1:0] sd_addr_t;

	typedef logic [7:0] byte_t;

	// command pins in the order {cs_n, ras_n, cas_n, we_n}
	// nop uses cs_n high so the reset value is a plain deselect
	typedef enum logic [3:0] {
		cmd_nop       = 4'b1111,
		cmd_active    = 4'b0011,
		cmd_read      = 4'b0101,
		cmd_write     = 4'b0100,
		cmd_precharge = 4'b0010,
		cmd_refresh   = 4'b0001,
		cmd_load_mode = 4'b0000
	} sd_cmd_t;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
// 8N1 only, no parity and no break detect; a frame with a low stop bit is dropped silently
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module uart_rx (
	input wire clk,
	input wire arst_n,
	input wire rxd,
	output sdram_test_pkg::byte_t data,
	output logic strobe
);
	localparam int cnt_w = $clog2(`SDT_CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] full_bit = cnt_w'(`SDT_CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] half_bit = cnt_w'(`SDT_CLKS_PER_BIT / 2 - 1);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_stop = 2'd3;

	logic rxd_meta;
	logic rxd_sync;
	logic [1:0] state;
	logic [cnt_w-1:0] timer;
	logic [2:0] bit_idx;
	sdram_test_pkg::byte_t shift_reg;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state <= st_idle;
			timer <= '0;
			bit_idx <= '0;
			strobe <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			strobe <= 1'b0;
			if (state != st_idle && timer != '0) begin
				timer <= timer - 1'b1;
			end else begin
				case (state)
					st_idle: begin
						// falling edge, aim for the middle of the start bit
						if (!rxd_sync) begin
							state <= st_start;
							timer <= half_bit;
						end
					end
					st_start: begin
						// glitch rejection
						state <= rxd_sync ? st_idle : st_data;
						timer <= full_bit;
						bit_idx <= '0;
					end
					st_data: begin
						timer <= full_bit;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
					default: begin
						state <= st_idle;
						strobe <= rxd_sync;
					end
				endcase
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == st_data && timer == '0)
			shift_reg <= {rxd_sync, shift_reg[7:1]};
		if (state == st_stop && timer == '0 && rxd_sync)
			data <= shift_reg;
	end

endmodule

`default_nettype wire

//--- src/uart_tx_fifo.sv
// 8N1 only; a byte written while the FIFO is full is dropped, and there is no full flag
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module uart_tx_fifo (
	input wire clk,
	input wire arst_n,
	input wire sdram_test_pkg::byte_t data,
	input wire strobe,
	output logic txd
);
	localparam int cnt_w = $clog2(`SDT_CLKS_PER_BIT);
	localparam logic [cnt_w-1:0] full_bit = cnt_w'(`SDT_CLKS_PER_BIT - 1);
	localparam int ptr_w = $clog2(`SDT_TX_FIFO_DEPTH);

	sdram_test_pkg::byte_t mem [`SDT_TX_FIFO_DEPTH];

	// extra pointer bit tells full from empty
	logic [ptr_w:0] wr_ptr;
	logic [ptr_w:0] rd_ptr;
	logic full;
	logic empty;

	logic sending;
	logic [cnt_w-1:0] timer;
	logic [3:0] bits_left;
	// stop bit above the data bits
	logic [8:0] frame;
	logic frame_done;
	logic load;
	logic shift;

	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
		(wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

	// end of the stop bit, so the next start bit follows back to back
	assign frame_done = !sending || (timer == '0 && bits_left == '0);
	assign load = frame_done && !empty;
	assign shift = sending && timer == '0 && bits_left != '0;

	always_ff @(posedge clk) begin
		if (strobe && !full)
			mem[wr_ptr[ptr_w-1:0]] <= data;
		if (load)
			frame <= {1'b1, mem[rd_ptr[ptr_w-1:0]]};
		else if (shift)
			frame <= {1'b1, frame[8:1]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			sending <= 1'b0;
			timer <= '0;
			bits_left <= '0;
			txd <= 1'b1;
		end else begin
			if (strobe && !full)
				wr_ptr <= wr_ptr + 1'b1;

			if (load) begin
				// start bit goes out now, 8 data bits and stop follow
				rd_ptr <= rd_ptr + 1'b1;
				sending <= 1'b1;
				txd <= 1'b0;
				timer <= full_bit;
				bits_left <= 4'd9;
			end else if (frame_done) begin
				sending <= 1'b0;
			end else if (shift) begin
				txd <= frame[0];
				bits_left <= bits_left - 1'b1;
				timer <= full_bit;
			end else begin
				timer <= timer - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sdram_controller.sv
// single-byte accesses only, burst length 1 with auto-precharge; an enable is taken only in idle
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_controller (
	input wire clk,
	input wire arst_n,
	output logic [`SDT_ROW_W-1:0] addr,
	output logic [1:0] bank_addr,
	inout wire sdram_test_pkg::byte_t data,
	output logic clock_enable,
	output logic cs_n,
	output logic ras_n,
	output logic cas_n,
	output logic we_n,
	output logic data_mask,
	input wire sdram_test_pkg::sd_addr_t wr_addr,
	input wire sdram_test_pkg::byte_t wr_data,
	input wire wr_enable,
	input wire sdram_test_pkg::sd_addr_t rd_addr,
	input wire rd_enable,
	output sdram_test_pkg::byte_t rd_data,
	output logic rd_ready,
	output logic busy
);
	localparam int timer_w = $clog2(`SDT_T_INIT);
	localparam int refi_w = $clog2(`SDT_T_REFI);

	localparam logic [3:0] s_powerup = 4'd0;
	localparam logic [3:0] s_init_ref1 = 4'd1;
	localparam logic [3:0] s_init_ref2 = 4'd2;
	localparam logic [3:0] s_load_mode = 4'd3;
	localparam logic [3:0] s_idle = 4'd4;
	localparam logic [3:0] s_activate = 4'd5;
	localparam logic [3:0] s_read = 4'd6;
	localparam logic [3:0] s_capture = 4'd7;
	localparam logic [3:0] s_write = 4'd8;
	localparam logic [3:0] s_wait = 4'd9;

	// burst length 1, sequential, CAS latency from the config
	localparam logic [`SDT_ROW_W-1:0] mode_word =
		{3'b000, 1'b0, 2'b00, 3'(`SDT_CAS), 1'b0, 3'b000};
	// A10 high selects all banks
	localparam logic [`SDT_ROW_W-1:0] all_banks = 13'h0400;

	sdram_test_pkg::sd_cmd_t cmd;
	logic [3:0] state;
	logic [3:0] next_state;
	logic [timer_w-1:0] timer;
	logic [refi_w-1:0] refi_cnt;
	logic refresh_due;
	logic req_read;
	logic dq_oe;
	sdram_test_pkg::sd_addr_t op_addr;
	sdram_test_pkg::sd_addr_t req_addr;
	sdram_test_pkg::byte_t req_data;

	// column with A10 set for auto-precharge
	function automatic logic [`SDT_ROW_W-1:0] col_word(input sdram_test_pkg::sd_addr_t a);
		logic [`SDT_ROW_W-1:0] w;
		w = '0;
		w[`SDT_COL_W-1:0] = a[`SDT_COL_W-1:0];
		w[10] = 1'b1;
		return w;
	endfunction

	assign {cs_n, ras_n, cas_n, we_n} = cmd;
	assign data = dq_oe ? req_data : 'z;
	assign op_addr = rd_enable ? rd_addr : wr_addr;

	always_ff @(posedge clk) begin
		if (state == s_idle && (rd_enable || wr_enable)) begin
			req_addr <= op_addr;
			req_data <= wr_data;
		end
		if (state == s_capture)
			rd_data <= data;
	end

	// refresh request, served the next time the FSM is idle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			refi_cnt <= refi_w'(`SDT_T_REFI - 1);
			refresh_due <= 1'b0;
		end else begin
			// cleared once the refresh command goes out
			if (state == s_idle && refresh_due && (rd_enable || wr_enable || busy))
				refresh_due <= 1'b0;
			if (refi_cnt == '0) begin
				refi_cnt <= refi_w'(`SDT_T_REFI - 1);
				refresh_due <= 1'b1;
			end else begin
				refi_cnt <= refi_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_powerup;
			next_state <= s_idle;
			timer <= timer_w'(`SDT_T_INIT - 1);
			cmd <= sdram_test_pkg::cmd_nop;
			addr <= '0;
			bank_addr <= '0;
			clock_enable <= 1'b0;
			data_mask <= 1'b1;
			busy <= 1'b1;
			rd_ready <= 1'b0;
			dq_oe <= 1'b0;
			req_read <= 1'b0;
		end else begin
			cmd <= sdram_test_pkg::cmd_nop;
			rd_ready <= 1'b0;
			dq_oe <= 1'b0;
			case (state)
				s_powerup: begin
					clock_enable <= 1'b1;
					if (timer == '0) begin
						cmd <= sdram_test_pkg::cmd_precharge;
						addr <= all_banks;
						state <= s_wait;
						timer <= timer_w'(`SDT_T_RP - 2);
						next_state <= s_init_ref1;
					end else begin
						timer <= timer - 1'b1;
					end
				end
				s_init_ref1, s_init_ref2: begin
					cmd <= sdram_test_pkg::cmd_refresh;
					state <= s_wait;
					timer <= timer_w'(`SDT_T_RC - 2);
					next_state <= (state == s_init_ref1) ? s_init_ref2 : s_load_mode;
				end
				s_load_mode: begin
					cmd <= sdram_test_pkg::cmd_load_mode;
					addr <= mode_word;
					bank_addr <= '0;
					data_mask <= 1'b0;
					state <= s_wait;
					timer <= '0;
					next_state <= s_idle;
				end
				s_idle: begin
					if (rd_enable || wr_enable) begin
						busy <= 1'b1;
						req_read <= rd_enable;
						state <= s_wait;
						if (refresh_due) begin
							// refresh first, the request is held in req_addr
							cmd <= sdram_test_pkg::cmd_refresh;
							timer <= timer_w'(`SDT_T_RC - 2);
							next_state <= s_activate;
						end else begin
							cmd <= sdram_test_pkg::cmd_active;
							bank_addr <= op_addr[`SDT_ADDR_W-1 -: 2];
							addr <= op_addr[`SDT_COL_W +: `SDT_ROW_W];
							timer <= timer_w'(`SDT_T_RCD - 2);
							next_state <= rd_enable ? s_read : s_write;
						end
					end else if (refresh_due) begin
						// busy goes up a clock ahead so no enable lands on the refresh
						busy <= 1'b1;
						if (busy) begin
							cmd <= sdram_test_pkg::cmd_refresh;
							state <= s_wait;
							timer <= timer_w'(`SDT_T_RC - 2);
							next_state <= s_idle;
						end
					end
				end
				s_activate: begin
					cmd <= sdram_test_pkg::cmd_active;
					bank_addr <= req_addr[`SDT_ADDR_W-1 -: 2];
					addr <= req_addr[`SDT_COL_W +: `SDT_ROW_W];
					state <= s_wait;
					timer <= timer_w'(`SDT_T_RCD - 2);
					next_state <= req_read ? s_read : s_write;
				end
				s_read: begin
					cmd <= sdram_test_pkg::cmd_read;
					addr <= col_word(req_addr);
					state <= s_wait;
					// capture lands CAS cycles after the device sees the read
					timer <= timer_w'(`SDT_CAS - 1);
					next_state <= s_capture;
				end
				s_capture: begin
					rd_ready <= 1'b1;
					busy <= 1'b0;
					state <= s_idle;
				end
				s_write: begin
					cmd <= sdram_test_pkg::cmd_write;
					addr <= col_word(req_addr);
					dq_oe <= 1'b1;
					state <= s_wait;
					// hold off the next activate until tRC has passed
					timer <= timer_w'(`SDT_T_RC - `SDT_T_RCD - 2);
					next_state <= s_idle;
				end
				default: begin
					if (timer == '0) begin
						state <= next_state;
						if (next_state == s_idle)
							busy <= 1'b0;
					end else begin
						timer <= timer - 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/sdram_monitor.sv
// one read in flight at most; characters typed during a read only update the address
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_monitor (
	input wire clk,
	input wire arst_n,
	input wire sdram_test_pkg::byte_t rx_data,
	input wire rx_strobe,
	output sdram_test_pkg::byte_t tx_data,
	output logic tx_strobe,
	output sdram_test_pkg::sd_addr_t wr_addr,
	output sdram_test_pkg::byte_t wr_data,
	output logic wr_enable,
	output sdram_test_pkg::sd_addr_t rd_addr,
	output logic rd_enable,
	input wire sdram_test_pkg::byte_t rd_data,
	input wire rd_ready,
	input wire busy
);
	localparam int interval_w = $clog2(`SDT_WRITE_INTERVAL);

	logic read_pending;
	logic [interval_w-1:0] interval_cnt;
	logic write_due;
	logic is_hex;
	logic [3:0] nibble;
	logic read_start;
	logic write_start;

	// hex digit decode
	always_comb begin
		is_hex = 1'b1;
		nibble = '0;
		if (rx_data >= "0" && rx_data <= "9")
			nibble = 4'(rx_data - "0");
		else if (rx_data >= "a" && rx_data <= "f")
			nibble = 4'(rx_data - "a" + 8'd10);
		else if (rx_data >= "A" && rx_data <= "F")
			nibble = 4'(rx_data - "A" + 8'd10);
		else
			is_hex = 1'b0;
	end

	assign write_due = interval_cnt == '0;

	// the enable still high this cycle means busy has not risen yet
	assign read_start = !busy && !rd_enable && !wr_enable && read_pending;
	assign write_start = !busy && !rd_enable && !wr_enable && !read_pending && write_due;

	always_ff @(posedge clk) begin
		// read data wins over an echo
		if (rd_ready)
			tx_data <= rd_data;
		else if (rx_strobe)
			tx_data <= is_hex ? rx_data : "!";
		// ascii space plus the low address bits
		if (write_start)
			wr_data <= 8'h20 + {1'b0, wr_addr[6:0]};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_strobe <= 1'b0;
			wr_addr <= '0;
			wr_enable <= 1'b0;
			rd_addr <= '0;
			rd_enable <= 1'b0;
			read_pending <= 1'b0;
			interval_cnt <= interval_w'(`SDT_WRITE_INTERVAL - 1);
		end else begin
			tx_strobe <= rd_ready || (rx_strobe && (is_hex || rx_data == 8'h0a));
			wr_enable <= write_start;
			rd_enable <= read_start;

			if (!write_due)
				interval_cnt <= interval_cnt - 1'b1;

			if (read_start)
				read_pending <= 1'b0;

			if (write_start)
				interval_cnt <= interval_w'(`SDT_WRITE_INTERVAL - 1);

			// the controller takes wr_addr while wr_enable is high
			if (wr_enable)
				wr_addr <= wr_addr + 1'b1;

			// a new command overrides a read being issued this cycle
			if (rx_strobe) begin
				if (is_hex) begin
					rd_addr <= {rd_addr[`SDT_ADDR_W-5:0], nibble};
				end else if (rx_data == 8'h0a) begin
					read_pending <= 1'b1;
				end else if (rx_data == "x") begin
					rd_addr <= '0;
					read_pending <= 1'b1;
				end else if (rx_data == ".") begin
					rd_addr <= rd_addr + 1'b1;
					read_pending <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sdram_test_top.sv
// no PLL and no pad cells; the SDRAM clock is expected to be clk itself
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_test_top (
	input wire clk,
	input wire arst_n,
	input wire rxd,
	output logic txd,
	output logic [`SDT_ROW_W-1:0] sdram_addr,
	output logic [1:0] sdram_bank,
	inout wire sdram_test_pkg::byte_t sdram_data,
	output logic sdram_cke,
	output logic sdram_cs_n,
	output logic sdram_ras_n,
	output logic sdram_cas_n,
	output logic sdram_we_n,
	output logic sdram_dqm
);
	sdram_test_pkg::byte_t rx_data;
	logic rx_strobe;
	sdram_test_pkg::byte_t tx_data;
	logic tx_strobe;

	// logical side of the controller
	sdram_test_pkg::sd_addr_t wr_addr;
	sdram_test_pkg::byte_t wr_data;
	logic wr_enable;
	sdram_test_pkg::sd_addr_t rd_addr;
	logic rd_enable;
	sdram_test_pkg::byte_t rd_data;
	logic rd_ready;
	logic busy;

	uart_rx rx_i (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.data(rx_data),
		.strobe(rx_strobe)
	);

	sdram_monitor monitor_i (
		.clk(clk),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.tx_data(tx_data),
		.tx_strobe(tx_strobe),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_enable(wr_enable),
		.rd_addr(rd_addr),
		.rd_enable(rd_enable),
		.rd_data(rd_data),
		.rd_ready(rd_ready),
		.busy(busy)
	);

	uart_tx_fifo tx_i (
		.clk(clk),
		.arst_n(arst_n),
		.data(tx_data),
		.strobe(tx_strobe),
		.txd(txd)
	);

	sdram_controller sdram_i (
		.clk(clk),
		.arst_n(arst_n),
		.addr(sdram_addr),
		.bank_addr(sdram_bank),
		.data(sdram_data),
		.clock_enable(sdram_cke),
		.cs_n(sdram_cs_n),
		.ras_n(sdram_ras_n),
		.cas_n(sdram_cas_n),
		.we_n(sdram_we_n),
		.data_mask(sdram_dqm),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_enable(wr_enable),
		.rd_addr(rd_addr),
		.rd_enable(rd_enable),
		.rd_data(rd_data),
		.rd_ready(rd_ready),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- tb/sdram_model.sv
// behavioural 8-bit SDRAM, burst length 1 and CAS latency 2 only; unwritten bytes read as x
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_model (
	input wire clk,
	input wire cke,
	input wire cs_n,
	input wire ras_n,
	input wire cas_n,
	input wire we_n,
	input wire dqm,
	input wire [`SDT_ROW_W-1:0] addr,
	input wire [1:0] ba,
	inout wire [7:0] dq,
	output logic init_done,
	output logic init_error,
	output logic access_error
);
	sdram_test_pkg::sd_cmd_t cmd;
	logic [7:0] mem [logic [`SDT_ADDR_W-1:0]];
	logic [`SDT_ROW_W-1:0] open_row [4];
	logic [3:0] row_open;
	logic [2:0] init_step;
	logic [7:0] pend_data;
	logic pend_valid;
	logic [7:0] dq_out;
	logic dq_oe;

	assign cmd = sdram_test_pkg::sd_cmd_t'({cs_n, ras_n, cas_n, we_n});
	assign dq = dq_oe ? dq_out : 'z;

	initial begin
		init_done = 1'b0;
		init_error = 1'b0;
		access_error = 1'b0;
		init_step = '0;
		row_open = '0;
		pend_valid = 1'b0;
		dq_oe = 1'b0;
		dq_out = '0;
	end

	// full byte address as bank:row:column
	function automatic logic [`SDT_ADDR_W-1:0] byte_addr(input logic [1:0] b,
		input logic [`SDT_COL_W-1:0] c);
		return {b, open_row[b], c};
	endfunction

	always @(posedge clk) begin
		// second cycle of CAS latency puts the data on the bus
		dq_oe <= pend_valid;
		dq_out <= pend_data;
		pend_valid <= 1'b0;
		if (cke && cmd != sdram_test_pkg::cmd_nop) begin
			if (!init_done) begin
				case (init_step)
					3'd0: init_error <= init_error ||
						cmd != sdram_test_pkg::cmd_precharge || !addr[10];
					3'd1, 3'd2: init_error <= init_error || cmd != sdram_test_pkg::cmd_refresh;
					default: begin
						init_error <= init_error || cmd != sdram_test_pkg::cmd_load_mode;
						init_done <= 1'b1;
					end
				endcase
				init_step <= init_step + 1'b1;
			end else begin
				case (cmd)
					sdram_test_pkg::cmd_active: begin
						if (row_open[ba])
							access_error <= 1'b1;
						open_row[ba] <= addr;
						row_open[ba] <= 1'b1;
					end
					sdram_test_pkg::cmd_read, sdram_test_pkg::cmd_write: begin
						if (!row_open[ba])
							access_error <= 1'b1;
						if (cmd == sdram_test_pkg::cmd_write) begin
							if (!dqm)
								mem[byte_addr(ba, addr[`SDT_COL_W-1:0])] = dq;
						end else begin
							pend_valid <= 1'b1;
							if (mem.exists(byte_addr(ba, addr[`SDT_COL_W-1:0])))
								pend_data <= mem[byte_addr(ba, addr[`SDT_COL_W-1:0])];
							else
								pend_data <= 8'hxx;
						end
						// auto-precharge closes the row
						if (addr[10])
							row_open[ba] <= 1'b0;
					end
					sdram_test_pkg::cmd_precharge: begin
						if (addr[10])
							row_open <= '0;
						else
							row_open[ba] <= 1'b0;
					end
					sdram_test_pkg::cmd_refresh: begin
						if (row_open != '0)
							access_error <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/sdram_test_properties.sv
// checks the controller's command bus and handshake; auto-precharge counts as a precharge
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_test_properties (
	input wire clk,
	input wire arst_n,
	input wire [`SDT_ROW_W-1:0] addr,
	input wire cs_n,
	input wire ras_n,
	input wire cas_n,
	input wire we_n,
	input wire rd_enable,
	input wire wr_enable,
	input wire busy
);
	logic [3:0] cmd;
	logic is_pre;
	logic is_act;
	logic is_ref;
	// count of assertion failures
	int fail_count = 0;

	assign cmd = {cs_n, ras_n, cas_n, we_n};
	// a read or write with A10 high closes its row as well
	assign is_pre = cmd == sdram_test_pkg::cmd_precharge ||
		((cmd == sdram_test_pkg::cmd_read || cmd == sdram_test_pkg::cmd_write) && addr[10]);
	assign is_act = cmd == sdram_test_pkg::cmd_active;
	assign is_ref = cmd == sdram_test_pkg::cmd_refresh;

	one_enable: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd_enable && wr_enable))
		else begin
			$error("read and write enabled together");
			fail_count++;
		end

	// an idle FSM answers an enable with a command on the next clock
	enable_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(rd_enable || wr_enable) |=> busy && (is_act || is_ref))
		else begin
			$error("enable raised while controller busy");
			fail_count++;
		end

	precharge_to_active: assert property (@(posedge clk) disable iff (!arst_n)
		is_pre |=> !is_act [*(`SDT_T_RP-1)])
		else begin
			$error("active issued before tRP after precharge");
			fail_count++;
		end

endmodule

bind sdram_controller sdram_test_properties props_i (
	.clk(clk),
	.arst_n(arst_n),
	.addr(addr),
	.cs_n(cs_n),
	.ras_n(ras_n),
	.cas_n(cas_n),
	.we_n(we_n),
	.rd_enable(rd_enable),
	.wr_enable(wr_enable),
	.busy(busy)
);

`default_nettype wire

//--- tb/sdram_test_tb.sv
// directed tests over the serial port; stops at the first mismatch, addresses limited to 8 bits
`timescale 1ns/1ps
`default_nettype none

`include "sdram_test_config.svh"

module sdram_test_tb;
	localparam int frame_cycles = 10 * `SDT_CLKS_PER_BIT;
	localparam int fill_writes = 256;
	localparam int fill_cycles = fill_writes * (`SDT_WRITE_INTERVAL + 8);
	localparam int byte_timeout = 8 * frame_cycles;
	// roughly 200 frames in and out over all tests, doubled
	localparam int watchdog_cycles = `SDT_T_INIT + fill_cycles + 400 * frame_cycles * 2 + 5000;

	logic clk;
	logic arst_n;
	logic rxd;
	wire txd;
	wire [`SDT_ROW_W-1:0] sdram_addr;
	wire [1:0] sdram_bank;
	wire [7:0] sdram_data;
	wire sdram_cke;
	wire sdram_cs_n;
	wire sdram_ras_n;
	wire sdram_cas_n;
	wire sdram_we_n;
	wire sdram_dqm;
	wire init_done;
	wire init_error;
	wire access_error;

	logic [7:0] rx_q [$];
	integer seed;

	sdram_test_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.txd(txd),
		.sdram_addr(sdram_addr),
		.sdram_bank(sdram_bank),
		.sdram_data(sdram_data),
		.sdram_cke(sdram_cke),
		.sdram_cs_n(sdram_cs_n),
		.sdram_ras_n(sdram_ras_n),
		.sdram_cas_n(sdram_cas_n),
		.sdram_we_n(sdram_we_n),
		.sdram_dqm(sdram_dqm)
	);

	sdram_model model_i (
		.clk(clk),
		.cke(sdram_cke),
		.cs_n(sdram_cs_n),
		.ras_n(sdram_ras_n),
		.cas_n(sdram_cas_n),
		.we_n(sdram_we_n),
		.dqm(sdram_dqm),
		.addr(sdram_addr),
		.ba(sdram_bank),
		.dq(sdram_data),
		.init_done(init_done),
		.init_error(init_error),
		.access_error(access_error)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		fail_run("run did not finish in time, watchdog expired");
	end

	// background receiver, samples each txd bit in its middle
	initial begin
		logic [7:0] b;
		forever begin
			@(negedge clk);
			if (txd === 1'b0) begin
				repeat (`SDT_CLKS_PER_BIT / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (`SDT_CLKS_PER_BIT) @(negedge clk);
					b[i] = txd;
				end
				repeat (`SDT_CLKS_PER_BIT) @(negedge clk);
				if (txd !== 1'b1)
					fail_run("stop bit on txd was not high");
				rx_q.push_back(b);
			end
		end
	end

	task automatic send_char(input logic [7:0] c);
		@(negedge clk);
		rxd = 1'b0;
		repeat (`SDT_CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd = c[i];
			repeat (`SDT_CLKS_PER_BIT) @(negedge clk);
		end
		rxd = 1'b1;
		repeat (`SDT_CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic expect_byte(input string name, input logic [7:0] expected);
		int waited;
		waited = 0;
		while (rx_q.size() == 0) begin
			@(negedge clk);
			waited++;
			if (waited > byte_timeout)
				fail_run($sformatf("no byte arrived on txd for %s", name));
		end
		check(name, rx_q.pop_front(), expected);
	endtask

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		return (n < 10) ? 8'(n) + "0" : 8'(n) - 8'd10 + "a";
	endfunction

	task automatic test_reset_idle();
		int waited;
		for (int i = 0; i < 100; i++) begin
			@(negedge clk);
			check("txd", txd, 1'b1);
		end
		check("bytes after reset", rx_q.size(), 0);
		waited = 0;
		while (!init_done) begin
			@(negedge clk);
			waited++;
			if (waited > `SDT_T_INIT + 200)
				fail_run("SDRAM init sequence never completed");
		end
		check("init_error", init_error, 1'b0);
	endtask

	task automatic test_echo();
		send_char("3");
		expect_byte("echo 3", "3");
		send_char("a");
		expect_byte("echo a", "a");
		send_char("F");
		expect_byte("echo F", "F");
		send_char("g");
		send_char("z");
		repeat (2 * frame_cycles) @(negedge clk);
		check("bytes after g z", rx_q.size(), 0);
	endtask

	task automatic test_step_reads();
		send_char("x");
		expect_byte("data at 0", 8'h20);
		send_char(".");
		expect_byte("data at 1", 8'h21);
		send_char(".");
		expect_byte("data at 2", 8'h22);
	endtask

	task automatic test_typed_read();
		// clear the address first so 40 is the whole address
		send_char("x");
		expect_byte("data at 0", 8'h20);
		send_char("4");
		expect_byte("echo 4", "4");
		send_char("0");
		expect_byte("echo 0", "0");
		send_char(8'h0a);
		expect_byte("newline echo", "!");
		expect_byte("data at 40", 8'h60);
	endtask

	task automatic test_random_reads();
		logic [7:0] a;
		for (int n = 0; n < 8; n++) begin
			a = 8'($random(seed));
			// leading zeros push out earlier digits
			for (int i = 0; i < 4; i++) begin
				send_char("0");
				expect_byte("echo 0", "0");
			end
			send_char(hex_char(a[7:4]));
			expect_byte("echo high digit", hex_char(a[7:4]));
			send_char(hex_char(a[3:0]));
			expect_byte("echo low digit", hex_char(a[3:0]));
			send_char(8'h0a);
			expect_byte("newline echo", "!");
			expect_byte($sformatf("data at %h", a), 8'h20 + (a & 8'h7f));
		end
	endtask

	task automatic test_reads_over_refresh();
		send_char("x");
		expect_byte("data at 0", 8'h20);
		// about eight refresh periods of back to back reads
		for (int i = 1; i <= 40; i++) begin
			send_char(".");
			expect_byte($sformatf("data at %h", i), 8'h20 + 8'(i));
		end
		check("access_error", access_error, 1'b0);
	endtask

	initial begin
		seed = 32'h9982;
		rxd = 1'b1;
		arst_n = 1'b0;
		repeat (4) @(negedge clk);
		// serial line high and SDRAM deselected while reset is held
		check("txd", txd, 1'b1);
		check("sdram_cke", sdram_cke, 1'b0);
		check("sdram_cs_n", sdram_cs_n, 1'b1);
		arst_n = 1'b1;
		test_reset_idle();
		test_echo();
		repeat (fill_cycles) @(negedge clk);
		test_step_reads();
		test_typed_read();
		test_random_reads();
		test_reads_over_refresh();
		if (dut_i.sdram_i.props_i.fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/sdram_test_pkg.sv
src/uart_rx.sv
src/uart_tx_fifo.sv
src/sdram_controller.sv
src/sdram_monitor.sv
src/sdram_test_top.sv
tb/sdram_model.sv
tb/sdram_test_properties.sv
tb/sdram_test_tb.sv
